/* logic/xphy_defines.svh */
// shared widths and depths for the 10G MAC to PHY interface block
// include this in every RTL file that sizes XGMII ports or reset chains

`ifndef XPHY_DEFINES_SVH
`define XPHY_DEFINES_SVH

`default_nettype none

// 64-bit XGMII data word of eight one-byte lanes
`define XGMII_DATA_W 64

// one control bit per lane
`define XGMII_CTRL_W 8

// depth of every reset synchronizer chain in both clock domains
// must stay at 2 or more
`define SYNC_STAGES 2

// consecutive words needed to raise or drop a fault flag
`define FAULT_COUNT 4

`default_nettype wire

`endif

/* logic/xgmii_pkg.sv */
// XGMII word format for the interface block
// control characters, the forced transmit and receive words,
// and the classification of received fault ordered sets
// import into any module that builds or inspects XGMII words

`include "xphy_defines.svh"
`default_nettype none

package xgmii_pkg;

   // lanes per XGMII word, one control bit each
   localparam int XGMII_LANES = `XGMII_CTRL_W;

   // control characters
   localparam logic [7:0] XGMII_IDLE = 8'h07;
   localparam logic [7:0] XGMII_SEQ  = 8'h9C;

   // lane 3 codes of a sequence ordered set
   localparam logic [7:0] FAULT_LOCAL  = 8'h01;
   localparam logic [7:0] FAULT_REMOTE = 8'h02;

   // all-idle word sent to the PHY while the transmit core is held
   localparam logic [`XGMII_DATA_W-1:0] IDLE_WORD_D = {XGMII_LANES{XGMII_IDLE}};
   localparam logic [`XGMII_CTRL_W-1:0] IDLE_WORD_C = '1;

   // local fault sequence handed to the MAC while the receive core is held
   // seq in lane 0, code in lane 3, everything else zero
   localparam logic [`XGMII_DATA_W-1:0] LF_WORD_D =
      {{(`XGMII_DATA_W-32){1'b0}}, FAULT_LOCAL, 16'h0000, XGMII_SEQ};
   localparam logic [`XGMII_CTRL_W-1:0] LF_WORD_C = {{(`XGMII_CTRL_W-1){1'b0}}, 1'b1};

   // what a received word looks like to the fault monitor
   typedef enum logic [1:0] {KIND_NONE, KIND_LOCAL, KIND_REMOTE} fault_kind_t;

endpackage

`default_nettype wire

/* logic/phy_reset_pkg.sv */
// reset sequencing types for the interface block
// the phase type gives a readable view of where the transmit core
// reset stands, it does not steer the reset chains
// import where the phase register is kept or observed

`default_nettype none

package phy_reset_pkg;

   // hold    condition bad, core is being held
   // settle  condition good, chain still draining
   // run     core reset released
   typedef enum logic [1:0]
   {
      PHASE_HOLD   = 2'd0,
      PHASE_SETTLE = 2'd1,
      PHASE_RUN    = 2'd2
   } reset_phase_t;

endpackage

`default_nettype wire

/* logic/core_reset_ctrl.sv */
// core reset conditioning in the clk156 domain
// holds the transmit and receive cores in reset until the transceiver
// reports reset-done, tx_fault is clear and a signal is detected
// each hold condition runs through a short chain before it reaches the core
// resetdone is a plain AND of the two reset-done inputs

`include "xphy_defines.svh"
`default_nettype none

module core_reset_ctrl
   import phy_reset_pkg::*;
(
   input  logic clk156,
   input  logic reset,
   input  logic tx_resetdone,
   input  logic rx_resetdone,
   input  logic tx_fault,
   input  logic signal_detect,
   output logic core_reset_tx,
   output logic core_reset_rx,
   output logic resetdone
);

   // index of the last chain stage
   localparam int LAST = `SYNC_STAGES - 1;

   logic tx_hold;
   logic rx_hold;

   // inputs come from the transceiver side, sample them through a chain
   (* ASYNC_REG = "TRUE" *) logic [`SYNC_STAGES-1:0] tx_sync;
   (* ASYNC_REG = "TRUE" *) logic [`SYNC_STAGES-1:0] rx_sync;

   // transmit side phase, kept for debug visibility
   reset_phase_t reset_phase;
   reset_phase_t phase_next;

   // hold a core while its reset-done is low, tx laser faults,
   // or the optics lose signal
   assign tx_hold = !tx_resetdone || tx_fault || !signal_detect;
   assign rx_hold = !rx_resetdone || tx_fault || !signal_detect;

   // combined reset-done straight through, no register
   assign resetdone = tx_resetdone && rx_resetdone;

   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         // both cores held from the start
         tx_sync <= '1;
         rx_sync <= '1;
      end
      else
      begin
         // shift the condition toward the core reset output
         tx_sync <= {tx_sync[LAST-1:0], tx_hold};
         rx_sync <= {rx_sync[LAST-1:0], rx_hold};
      end
   end

   // last stage drives the cores
   assign core_reset_tx = tx_sync[LAST];
   assign core_reset_rx = rx_sync[LAST];

   // phase tracks the same edge that moves the chain
   always_comb
   begin
      if (tx_hold)
      begin
         phase_next = PHASE_HOLD;
      end
      else if (|tx_sync[LAST-1:0])
      begin
         // a held sample is still moving down the chain
         phase_next = PHASE_SETTLE;
      end
      else
      begin
         phase_next = PHASE_RUN;
      end
   end

   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         reset_phase <= PHASE_HOLD;
      end
      else
      begin
         reset_phase <= phase_next;
      end
   end

endmodule

`default_nettype wire

/* logic/xcvr_reset_sync.sv */
// carries the clk156 core resets into the txclk322 transceiver domain
// three separate chains so each reset can be placed on its own
// all chains are preset by reset and release two txclk322 edges
// after their source drops

`include "xphy_defines.svh"
`default_nettype none

module xcvr_reset_sync
(
   input  logic txclk322,
   input  logic reset,
   input  logic core_reset_tx,
   input  logic core_reset_rx,
   output logic txreset322,
   output logic rxreset322,
   output logic dclk_reset
);

   localparam int LAST = `SYNC_STAGES - 1;

   (* ASYNC_REG = "TRUE" *) logic [`SYNC_STAGES-1:0] txr_sync;
   (* ASYNC_REG = "TRUE" *) logic [`SYNC_STAGES-1:0] rxr_sync;
   // dclk reset follows the receive core, on its own chain
   (* ASYNC_REG = "TRUE" *) logic [`SYNC_STAGES-1:0] dclk_sync;

   always_ff @(posedge txclk322 or posedge reset)
   begin
      if (reset)
      begin
         txr_sync  <= '1;
         rxr_sync  <= '1;
         dclk_sync <= '1;
      end
      else
      begin
         txr_sync  <= {txr_sync[LAST-1:0], core_reset_tx};
         rxr_sync  <= {rxr_sync[LAST-1:0], core_reset_rx};
         dclk_sync <= {dclk_sync[LAST-1:0], core_reset_rx};
      end
   end

   assign txreset322 = txr_sync[LAST];
   assign rxreset322 = rxr_sync[LAST];
   assign dclk_reset = dclk_sync[LAST];

endmodule

`default_nettype wire

/* logic/xgmii_tx_stage.sv */
// transmit XGMII register stage, MAC toward PHY
// one clk156 cycle of latency for data and control together
// while the transmit core is held in reset the PHY gets idle words,
// so a frame cut short by the reset never leaves the block

`include "xphy_defines.svh"
`default_nettype none

module xgmii_tx_stage
   import xgmii_pkg::*;
(
   input  logic                     clk156,
   input  logic                     reset,
   input  logic                     core_reset_tx,
   input  logic [`XGMII_DATA_W-1:0] xgmii_txd,
   input  logic [`XGMII_CTRL_W-1:0] xgmii_txc,
   output logic [`XGMII_DATA_W-1:0] xgmii_txd_int,
   output logic [`XGMII_CTRL_W-1:0] xgmii_txc_int
);

   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         // PHY sees idles from the moment reset is applied
         xgmii_txd_int <= IDLE_WORD_D;
         xgmii_txc_int <= IDLE_WORD_C;
      end
      else if (core_reset_tx)
      begin
         // core held, replace whatever the MAC drives
         xgmii_txd_int <= IDLE_WORD_D;
         xgmii_txc_int <= IDLE_WORD_C;
      end
      else
      begin
         // plain one cycle passthrough
         xgmii_txd_int <= xgmii_txd;
         xgmii_txc_int <= xgmii_txc;
      end
   end

endmodule

`default_nettype wire

/* logic/xgmii_rx_monitor.sv */
// receive XGMII register stage from PHY toward MAC with a fault monitor
// the word is registered once and replaced by the local fault sequence
// while the receive core is held in reset
// fault flags watch the raw PHY words rather than the forced output
// and need FAULT_COUNT consecutive words to change state

`include "xphy_defines.svh"
`default_nettype none

module xgmii_rx_monitor
   import xgmii_pkg::*;
(
   input  logic                     clk156,
   input  logic                     reset,
   input  logic                     core_reset_rx,
   input  logic [`XGMII_DATA_W-1:0] xgmii_rxd_int,
   input  logic [`XGMII_CTRL_W-1:0] xgmii_rxc_int,
   output logic [`XGMII_DATA_W-1:0] xgmii_rxd,
   output logic [`XGMII_CTRL_W-1:0] xgmii_rxc,
   output logic                     local_fault,
   output logic                     remote_fault
);

   // run counters only need to reach FAULT_COUNT-1
   localparam int CNT_W = $clog2(`FAULT_COUNT);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`FAULT_COUNT - 1);

   fault_kind_t rx_kind;
   logic [1:0]  fault_flags;

   // data path
   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         // MAC sees local fault from the moment reset is applied
         xgmii_rxd <= LF_WORD_D;
         xgmii_rxc <= LF_WORD_C;
      end
      else if (core_reset_rx)
      begin
         // MAC sees local fault while the receive side is not up
         xgmii_rxd <= LF_WORD_D;
         xgmii_rxc <= LF_WORD_C;
      end
      else
      begin
         xgmii_rxd <= xgmii_rxd_int;
         xgmii_rxc <= xgmii_rxc_int;
      end
   end

   // sequence ordered set sits in the low column
   // seq control char in lane 0, zero lanes 1 and 2, code in lane 3
   always_comb
   begin
      rx_kind = KIND_NONE;
      if (xgmii_rxc_int[3:0] == 4'b0001 && xgmii_rxd_int[7:0] == XGMII_SEQ &&
          xgmii_rxd_int[23:8] == 16'h0000)
      begin
         if (xgmii_rxd_int[31:24] == FAULT_LOCAL)
         begin
            rx_kind = KIND_LOCAL;
         end
         else if (xgmii_rxd_int[31:24] == FAULT_REMOTE)
         begin
            rx_kind = KIND_REMOTE;
         end
      end
   end

   // one tracker per fault kind with bit 0 local and bit 1 remote
   for (genvar k = 0; k < 2; k++)
   begin : g_fault
      localparam fault_kind_t WATCH = (k == 0) ? KIND_LOCAL : KIND_REMOTE;

      logic [CNT_W-1:0] hit_cnt;
      logic [CNT_W-1:0] miss_cnt;
      logic             flag;

      always_ff @(posedge clk156 or posedge reset)
      begin
         if (reset)
         begin
            hit_cnt  <= '0;
            miss_cnt <= '0;
            flag     <= 1'b0;
         end
         else if (rx_kind == WATCH)
         begin
            // matching word breaks any run of misses
            miss_cnt <= '0;
            if (hit_cnt == CNT_LAST)
               flag <= 1'b1;
            else
               hit_cnt <= hit_cnt + 1'b1;
         end
         else
         begin
            // idle, data, or the other fault kind all count as a miss
            hit_cnt <= '0;
            if (miss_cnt == CNT_LAST)
               flag <= 1'b0;
            else
               miss_cnt <= miss_cnt + 1'b1;
         end
      end

      assign fault_flags[k] = flag;
   end

   assign local_fault  = fault_flags[0];
   assign remote_fault = fault_flags[1];

endmodule

`default_nettype wire

/* logic/xphy_if_top.sv */
// top of the 10G MAC to PHY interface block
// ties the clk156 reset conditioning, the txclk322 reset chains,
// and the two XGMII register stages together
// xphy_reset is handed straight back out as areset for the PHY side

`include "xphy_defines.svh"
`default_nettype none

module xphy_if_top
(
   input  logic                     clk156,
   input  logic                     reset,
   input  logic                     txclk322,
   input  logic                     xphy_reset,
   input  logic                     tx_resetdone,
   input  logic                     rx_resetdone,
   input  logic                     tx_fault,
   input  logic                     signal_detect,
   input  logic [`XGMII_DATA_W-1:0] xgmii_txd,
   input  logic [`XGMII_CTRL_W-1:0] xgmii_txc,
   input  logic [`XGMII_DATA_W-1:0] xgmii_rxd_int,
   input  logic [`XGMII_CTRL_W-1:0] xgmii_rxc_int,
   output logic                     areset,
   output logic                     dclk_reset,
   output logic                     resetdone,
   output logic                     txreset322,
   output logic                     rxreset322,
   output logic [`XGMII_DATA_W-1:0] xgmii_txd_int,
   output logic [`XGMII_CTRL_W-1:0] xgmii_txc_int,
   output logic [`XGMII_DATA_W-1:0] xgmii_rxd,
   output logic [`XGMII_CTRL_W-1:0] xgmii_rxc,
   output logic                     local_fault,
   output logic                     remote_fault
);

   // core resets, clk156 domain
   logic core_reset_tx;
   logic core_reset_rx;

   assign areset = xphy_reset;

   core_reset_ctrl u_core_reset_ctrl
   (
      .clk156        (clk156),
      .reset         (reset),
      .tx_resetdone  (tx_resetdone),
      .rx_resetdone  (rx_resetdone),
      .tx_fault      (tx_fault),
      .signal_detect (signal_detect),
      .core_reset_tx (core_reset_tx),
      .core_reset_rx (core_reset_rx),
      .resetdone     (resetdone)
   );

   // crosses into the transceiver clock
   xcvr_reset_sync u_xcvr_reset_sync
   (
      .txclk322      (txclk322),
      .reset         (reset),
      .core_reset_tx (core_reset_tx),
      .core_reset_rx (core_reset_rx),
      .txreset322    (txreset322),
      .rxreset322    (rxreset322),
      .dclk_reset    (dclk_reset)
   );

   xgmii_tx_stage u_xgmii_tx_stage
   (
      .clk156        (clk156),
      .reset         (reset),
      .core_reset_tx (core_reset_tx),
      .xgmii_txd     (xgmii_txd),
      .xgmii_txc     (xgmii_txc),
      .xgmii_txd_int (xgmii_txd_int),
      .xgmii_txc_int (xgmii_txc_int)
   );

   xgmii_rx_monitor u_xgmii_rx_monitor
   (
      .clk156        (clk156),
      .reset         (reset),
      .core_reset_rx (core_reset_rx),
      .xgmii_rxd_int (xgmii_rxd_int),
      .xgmii_rxc_int (xgmii_rxc_int),
      .xgmii_rxd     (xgmii_rxd),
      .xgmii_rxc     (xgmii_rxc),
      .local_fault   (local_fault),
      .remote_fault  (remote_fault)
   );

endmodule

`default_nettype wire

/* sim/xphy_if_asserts.sv */
// concurrent checks on the interface block bound into the top level
// reaches the internal core reset and transmit reset phase through the bind port list

`include "xphy_defines.svh"
`default_nettype none

module xphy_if_asserts
   import phy_reset_pkg::*;
(
   input wire                     clk156,
   input wire                     reset,
   input wire                     core_reset_tx,
   input reset_phase_t            reset_phase,
   input wire                     txreset322,
   input wire [`XGMII_CTRL_W-1:0] xgmii_txc_int,
   input wire                     local_fault,
   input wire                     remote_fault
);

   // a settled core reset must be seen in the txclk322 domain
   a_txreset_follows : assert property (@(posedge clk156) disable iff (reset)
      core_reset_tx && $past(core_reset_tx) && $past(core_reset_tx, 2) |-> txreset322)
      else $error("txreset322 low while core_reset_tx held");

   // a transmit core running for three cycles has released the txclk322 reset
   a_txreset_release : assert property (@(posedge clk156) disable iff (reset)
      reset_phase == PHASE_RUN && $past(reset_phase) == PHASE_RUN &&
      $past(reset_phase, 2) == PHASE_RUN |-> !txreset322)
      else $error("txreset322 still high after the transmit core reset released");

   // held transmit core gives all control bits set next cycle
   a_tx_idle : assert property (@(posedge clk156) disable iff (reset)
      core_reset_tx |=> (xgmii_txc_int == '1))
      else $error("transmit word not idle during core reset");

   a_fault_excl : assert property (@(posedge clk156) disable iff (reset)
      !(local_fault && remote_fault))
      else $error("local and remote fault flags both set");

endmodule

bind xphy_if_top xphy_if_asserts u_asserts
(
   .clk156        (clk156),
   .reset         (reset),
   .core_reset_tx (core_reset_tx),
   .reset_phase   (u_core_reset_ctrl.reset_phase),
   .txreset322    (txreset322),
   .xgmii_txc_int (xgmii_txc_int),
   .local_fault   (local_fault),
   .remote_fault  (remote_fault)
);

`default_nettype wire

/* sim/xphy_if_tb.sv */
// directed testbench for the 10G MAC to PHY interface block
// clk156 and txclk322 run free and inputs change on the falling clk156 edge
// outputs are sampled on the falling edge half a cycle after they settle
// each behavior is a task and the error count decides the final verdict

`include "xphy_defines.svh"
`default_nettype none

module xphy_if_tb
   import xgmii_pkg::*;
();

   localparam int MAX_CYCLES = 400;

   logic clk156;
   logic txclk322;
   logic reset;
   logic xphy_reset;
   logic tx_resetdone;
   logic rx_resetdone;
   logic tx_fault;
   logic signal_detect;
   logic [`XGMII_DATA_W-1:0] xgmii_txd;
   logic [`XGMII_CTRL_W-1:0] xgmii_txc;
   logic [`XGMII_DATA_W-1:0] xgmii_rxd_int;
   logic [`XGMII_CTRL_W-1:0] xgmii_rxc_int;
   wire areset;
   wire dclk_reset;
   wire resetdone;
   wire txreset322;
   wire rxreset322;
   wire [`XGMII_DATA_W-1:0] xgmii_txd_int;
   wire [`XGMII_CTRL_W-1:0] xgmii_txc_int;
   wire [`XGMII_DATA_W-1:0] xgmii_rxd;
   wire [`XGMII_CTRL_W-1:0] xgmii_rxc;
   wire local_fault;
   wire remote_fault;

   int errors;
   int checks;
   int cycles;
   logic [31:0] lfsr_state;

   // expected forced words built from the XGMII format
   logic [63:0] idle_d;
   logic [63:0] lf_d;
   logic [63:0] seq_local_d;
   logic [63:0] seq_remote_d;

   xphy_if_top i_dut
   (
      .clk156        (clk156),
      .reset         (reset),
      .txclk322      (txclk322),
      .xphy_reset    (xphy_reset),
      .tx_resetdone  (tx_resetdone),
      .rx_resetdone  (rx_resetdone),
      .tx_fault      (tx_fault),
      .signal_detect (signal_detect),
      .xgmii_txd     (xgmii_txd),
      .xgmii_txc     (xgmii_txc),
      .xgmii_rxd_int (xgmii_rxd_int),
      .xgmii_rxc_int (xgmii_rxc_int),
      .areset        (areset),
      .dclk_reset    (dclk_reset),
      .resetdone     (resetdone),
      .txreset322    (txreset322),
      .rxreset322    (rxreset322),
      .xgmii_txd_int (xgmii_txd_int),
      .xgmii_txc_int (xgmii_txc_int),
      .xgmii_rxd     (xgmii_rxd),
      .xgmii_rxc     (xgmii_rxc),
      .local_fault   (local_fault),
      .remote_fault  (remote_fault)
   );

   always #50 clk156 = ~clk156;
   always #24 txclk322 = ~txclk322;

   // run limit well above the sum of all tasks
   always @(posedge clk156)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout after %0d clk156 cycles, a test stalled", cycles);
         $display("Test failed");
         $finish;
      end
   end

   // galois lfsr with x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 32'h8020_0003;
      return n;
   endfunction

   // one lfsr step per bit taken
   task automatic random_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[62:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
   endtask

   // waits a few cycles for the transmit core reset to reach a level
   task automatic wait_core_tx(input logic level);
      int n;
      n = 0;
      while (i_dut.core_reset_tx !== level && n < 3)
      begin
         @(negedge clk156);
         n++;
      end
      checks++;
      if (i_dut.core_reset_tx !== level)
      begin
         errors++;
         $display("core_reset_tx never reached %b at %0t", level, $time);
      end
   endtask

   task automatic wait_core_rx(input logic level);
      int n;
      n = 0;
      while (i_dut.core_reset_rx !== level && n < 3)
      begin
         @(negedge clk156);
         n++;
      end
      checks++;
      if (i_dut.core_reset_rx !== level)
      begin
         errors++;
         $display("core_reset_rx never reached %b at %0t", level, $time);
      end
   endtask

   // outputs while reset is still applied
   task automatic reset_state();
      checks += 10;
      if (areset !== 1'b1)
         report_mismatch("areset", areset, 1'b1);
      if (txreset322 !== 1'b1)
         report_mismatch("txreset322", txreset322, 1'b1);
      if (rxreset322 !== 1'b1)
         report_mismatch("rxreset322", rxreset322, 1'b1);
      if (dclk_reset !== 1'b1)
         report_mismatch("dclk_reset", dclk_reset, 1'b1);
      if (xgmii_txd_int !== idle_d)
         report_mismatch("xgmii_txd_int", xgmii_txd_int, idle_d);
      if (xgmii_txc_int !== 8'hFF)
         report_mismatch("xgmii_txc_int", xgmii_txc_int, 8'hFF);
      if (xgmii_rxd !== lf_d)
         report_mismatch("xgmii_rxd", xgmii_rxd, lf_d);
      if (xgmii_rxc !== 8'h01)
         report_mismatch("xgmii_rxc", xgmii_rxc, 8'h01);
      if (local_fault !== 1'b0)
         report_mismatch("local_fault", local_fault, 1'b0);
      if (remote_fault !== 1'b0)
         report_mismatch("remote_fault", remote_fault, 1'b0);
   endtask

   task automatic reset_release();
      wait_core_tx(1'b0);
      wait_core_rx(1'b0);
      checks++;
      if (areset !== 1'b0)
         report_mismatch("areset", areset, 1'b0);
      // transceiver side follows within two txclk322 edges
      repeat (2) @(negedge clk156);
      checks++;
      if (txreset322 !== 1'b0 || rxreset322 !== 1'b0 || dclk_reset !== 1'b0)
      begin
         errors++;
         $display("txclk322 resets still high after core release at %0t", $time);
      end
   endtask

   // drive one set of conditions and check both reset levels
   task automatic apply_condition(input logic txd_in, input logic rxd_in,
                                  input logic fault_in, input logic sd_in,
                                  input logic exp_tx, input logic exp_rx);
      @(negedge clk156);
      tx_resetdone  = txd_in;
      rx_resetdone  = rxd_in;
      tx_fault      = fault_in;
      signal_detect = sd_in;
      #1;
      checks++;
      if (resetdone !== (txd_in && rxd_in))
         report_mismatch("resetdone", resetdone, txd_in && rxd_in);
      // two clk156 edges through the chain
      repeat (2) @(negedge clk156);
      checks += 2;
      if (i_dut.core_reset_tx !== exp_tx)
         report_mismatch("core_reset_tx", i_dut.core_reset_tx, exp_tx);
      if (i_dut.core_reset_rx !== exp_rx)
         report_mismatch("core_reset_rx", i_dut.core_reset_rx, exp_rx);
      repeat (2) @(negedge clk156);
      checks += 3;
      if (txreset322 !== exp_tx)
         report_mismatch("txreset322", txreset322, exp_tx);
      if (rxreset322 !== exp_rx)
         report_mismatch("rxreset322", rxreset322, exp_rx);
      if (dclk_reset !== exp_rx)
         report_mismatch("dclk_reset", dclk_reset, exp_rx);
   endtask

   task automatic fault_gating();
      apply_condition(1, 1, 1, 1, 1, 1);
      apply_condition(1, 1, 0, 1, 0, 0);
      apply_condition(1, 1, 0, 0, 1, 1);
      apply_condition(1, 1, 0, 1, 0, 0);
      apply_condition(0, 1, 0, 1, 1, 0);
      apply_condition(1, 1, 0, 1, 0, 0);
      apply_condition(1, 0, 0, 1, 0, 1);
      apply_condition(1, 1, 0, 1, 0, 0);
   endtask

   task automatic tx_passthrough();
      logic [63:0] d;
      logic [63:0] c;
      logic [63:0] prev_d;
      logic [63:0] prev_c;
      prev_d = '0;
      prev_c = '0;
      for (int i = 0; i <= 16; i++)
      begin
         @(negedge clk156);
         if (i > 0)
         begin
            checks += 2;
            if (xgmii_txd_int !== prev_d)
               report_mismatch("xgmii_txd_int", xgmii_txd_int, prev_d);
            if (xgmii_txc_int !== prev_c[7:0])
               report_mismatch("xgmii_txc_int", xgmii_txc_int, prev_c);
         end
         if (i < 16)
         begin
            random_bits(64, d);
            random_bits(8, c);
            xgmii_txd = d;
            xgmii_txc = c[7:0];
            prev_d = d;
            prev_c = c;
         end
      end
   endtask

   task automatic tx_idle_forcing();
      logic [63:0] d;
      logic [63:0] c;
      @(negedge clk156);
      tx_resetdone = 1'b0;
      wait_core_tx(1'b1);
      for (int i = 0; i < 6; i++)
      begin
         random_bits(64, d);
         random_bits(8, c);
         xgmii_txd = d;
         xgmii_txc = c[7:0];
         @(negedge clk156);
         checks += 2;
         if (xgmii_txd_int !== idle_d)
            report_mismatch("xgmii_txd_int", xgmii_txd_int, idle_d);
         if (xgmii_txc_int !== 8'hFF)
            report_mismatch("xgmii_txc_int", xgmii_txc_int, 8'hFF);
      end
      tx_resetdone = 1'b1;
      wait_core_tx(1'b0);
   endtask

   task automatic rx_passthrough();
      logic [63:0] d;
      logic [63:0] c;
      logic [63:0] prev_d;
      logic [63:0] prev_c;
      prev_d = '0;
      prev_c = '0;
      for (int i = 0; i <= 16; i++)
      begin
         @(negedge clk156);
         if (i > 0)
         begin
            checks += 2;
            if (xgmii_rxd !== prev_d)
               report_mismatch("xgmii_rxd", xgmii_rxd, prev_d);
            if (xgmii_rxc !== prev_c[7:0])
               report_mismatch("xgmii_rxc", xgmii_rxc, prev_c);
         end
         if (i < 16)
         begin
            random_bits(64, d);
            random_bits(8, c);
            xgmii_rxd_int = d;
            xgmii_rxc_int = c[7:0];
            prev_d = d;
            prev_c = c;
         end
      end
      // now hold the receive core and expect local fault words
      rx_resetdone = 1'b0;
      wait_core_rx(1'b1);
      for (int i = 0; i < 6; i++)
      begin
         random_bits(64, d);
         xgmii_rxd_int = d;
         @(negedge clk156);
         checks += 2;
         if (xgmii_rxd !== lf_d)
            report_mismatch("xgmii_rxd", xgmii_rxd, lf_d);
         if (xgmii_rxc !== 8'h01)
            report_mismatch("xgmii_rxc", xgmii_rxc, 8'h01);
      end
      rx_resetdone = 1'b1;
      wait_core_rx(1'b0);
   endtask

   // sends n copies of a word and checks both flags after each one
   task automatic send_and_check(input logic [63:0] d, input logic [7:0] c, input int n,
                                 input logic last_lf, input logic last_rf);
      for (int i = 1; i <= n; i++)
      begin
         xgmii_rxd_int = d;
         xgmii_rxc_int = c;
         @(negedge clk156);
         // flags only change on the word that completes a run
         checks += 2;
         if (local_fault !== last_lf)
            report_mismatch("local_fault", local_fault, last_lf);
         if (remote_fault !== last_rf)
            report_mismatch("remote_fault", remote_fault, last_rf);
      end
   endtask

   task automatic fault_detection();
      @(negedge clk156);
      send_and_check(idle_d, 8'hFF, `FAULT_COUNT, 0, 0);
      send_and_check(seq_local_d, 8'h01, `FAULT_COUNT - 1, 0, 0);
      send_and_check(seq_local_d, 8'h01, 1, 1, 0);
      send_and_check(seq_remote_d, 8'h01, `FAULT_COUNT - 1, 1, 0);
      send_and_check(seq_remote_d, 8'h01, 1, 0, 1);
      send_and_check(idle_d, 8'hFF, `FAULT_COUNT - 1, 0, 1);
      send_and_check(idle_d, 8'hFF, 1, 0, 0);
   endtask

   initial
   begin
      errors        = 0;
      checks        = 0;
      cycles        = 0;
      lfsr_state    = 32'd31347;
      idle_d        = {8{XGMII_IDLE}};
      lf_d          = {32'h0, FAULT_LOCAL, 16'h0000, XGMII_SEQ};
      seq_local_d   = {32'h0, FAULT_LOCAL, 16'h0000, XGMII_SEQ};
      seq_remote_d  = {32'h0, FAULT_REMOTE, 16'h0000, XGMII_SEQ};
      clk156        = 1'b0;
      txclk322      = 1'b0;
      reset         = 1'b1;
      xphy_reset    = 1'b1;
      tx_resetdone  = 1'b1;
      rx_resetdone  = 1'b1;
      tx_fault      = 1'b0;
      signal_detect = 1'b1;
      xgmii_txd     = {8{XGMII_IDLE}};
      xgmii_txc     = 8'hFF;
      xgmii_rxd_int = {8{XGMII_IDLE}};
      xgmii_rxc_int = 8'hFF;
      repeat (3) @(negedge clk156);
      reset_state();
      reset      = 1'b0;
      xphy_reset = 1'b0;
      reset_release();
      fault_gating();
      tx_passthrough();
      tx_idle_forcing();
      rx_passthrough();
      fault_detection();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+logic
logic/xgmii_pkg.sv
logic/phy_reset_pkg.sv
logic/core_reset_ctrl.sv
logic/xcvr_reset_sync.sv
logic/xgmii_tx_stage.sv
logic/xgmii_rx_monitor.sv
logic/xphy_if_top.sv
sim/xphy_if_asserts.sv
sim/xphy_if_tb.sv

/* Makefile */
# Verilator build and run for the XGMII PHY interface block

TOP := xphy_if_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)
	verilator --lint-only -Wall +incdir+logic logic/xgmii_pkg.sv logic/phy_reset_pkg.sv \
		logic/core_reset_ctrl.sv logic/xcvr_reset_sync.sv logic/xgmii_tx_stage.sv \
		logic/xgmii_rx_monitor.sv logic/xphy_if_top.sv --top-module xphy_if_top

clean:
	rm -rf obj_dir $(LOG)
